// File: design/icache_settings.svh
//////////////////////////////////////////////////
// Instruction cache size settings
// Address, beat, way, set and line dimensions
//////////////////////////////////////////////////

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Fetch and memory address width
`define ICACHE_ADDR_W 32
// One memory beat, also one fetch response
`define ICACHE_BEAT_W 64
// Associativity
`define ICACHE_WAYS 2
// Sets per way
`define ICACHE_SETS 16
// Beats per line, 32 bytes in all
`define ICACHE_LINE_BEATS 4

`endif

// File: design/icache_pkg.sv
//////////////////////////////////////////////////
// Instruction cache types
// Address fields, way vectors and FSM states
//////////////////////////////////////////////////

`include "icache_settings.svh"

package icache_pkg;

	// Field widths of a fetch address
	localparam int BYTE_OFF_W = $clog2(`ICACHE_BEAT_W / 8);
	localparam int OFFSET_W = $clog2(`ICACHE_LINE_BEATS);
	localparam int INDEX_W = $clog2(`ICACHE_SETS);
	localparam int TAG_W = `ICACHE_ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;
	localparam int WAY_W = $clog2(`ICACHE_WAYS);

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
	typedef logic [`ICACHE_BEAT_W-1:0] beat_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_WAYS-1:0] way_vec_t;
	// Index in the upper bits, beat offset below
	typedef logic [INDEX_W+OFFSET_W-1:0] data_addr_t;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_refill_req,
		st_refill_data,
		st_fence
	} ctrl_state_t;

endpackage

// File: design/icache_ctrl.sv
//////////////////////////////////////////////////
// Instruction cache controller
// Request accept, lookup, miss burst and refill,
// fence handling and fetch response valid
//////////////////////////////////////////////////

module icache_ctrl (
	input logic CLK,
	input logic reset,
	input logic ifu_req_valid,
	output logic ifu_req_ready,
	output logic ifu_rsp_valid,
	input logic ifu_rsp_ready,
	input logic fence,
	output logic mem_ar_valid,
	input logic mem_ar_ready,
	input logic mem_r_valid,
	output logic mem_r_ready,
	input logic mem_r_last,
	input icache_pkg::way_vec_t hit,
	input icache_pkg::way_vec_t victim,
	output logic lookup_en,
	output icache_pkg::way_vec_t refill_we,
	output icache_pkg::offset_t refill_offset,
	output icache_pkg::way_vec_t fill_valid,
	output logic flush
);
	import icache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic fence_pend;
	logic rsp_valid_q;
	way_vec_t victim_q;
	offset_t beat_cnt;
	logic req_fire;
	logic ar_fire;
	logic r_fire;
	logic r_done;
	logic lookup_miss;

	assign req_fire = ifu_req_valid & ifu_req_ready;
	assign ar_fire = mem_ar_valid & mem_ar_ready;
	assign r_fire = mem_r_valid & mem_r_ready;
	assign r_done = r_fire & mem_r_last;
	assign lookup_miss = (state == st_lookup) & ~(|hit);

	// Accept only when idle and the previous response leaves this cycle
	assign ifu_req_ready = (state == st_idle) & ~fence_pend & (~rsp_valid_q | ifu_rsp_ready);
	assign ifu_rsp_valid = rsp_valid_q;
	assign mem_ar_valid = (state == st_refill_req);
	// Memory is never stalled during a refill
	assign mem_r_ready = (state == st_refill_data);
	// RAM read on a new request, and again right after the last beat
	assign lookup_en = req_fire | r_done;
	assign refill_we = r_fire ? victim_q : '0;
	assign refill_offset = beat_cnt;
	assign fill_valid = r_done ? victim_q : '0;
	assign flush = (state == st_fence);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (req_fire) begin
					state_nxt = st_lookup;
				end else if (fence_pend & ~rsp_valid_q) begin
					// Nothing in flight so the clear is safe
					state_nxt = st_fence;
				end
			end
			st_lookup: begin
				state_nxt = (|hit) ? st_idle : st_refill_req;
			end
			st_refill_req: begin
				if (ar_fire) begin
					state_nxt = st_refill_data;
				end
			end
			st_refill_data: begin
				// Second lookup that now hits
				if (r_done) begin
					state_nxt = st_lookup;
				end
			end
			st_fence: begin
				state_nxt = st_idle;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= st_idle;
			fence_pend <= 1'b0;
			rsp_valid_q <= 1'b0;
			victim_q <= '0;
			beat_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_fence) begin
				fence_pend <= 1'b0;
			end
			// A new pulse wins over the clear
			if (fence) begin
				fence_pend <= 1'b1;
			end
			rsp_valid_q <= ((state == st_lookup) & (|hit)) | (rsp_valid_q & ~ifu_rsp_ready);
			// Victim fixed for the whole burst
			if (lookup_miss) begin
				victim_q <= victim;
				beat_cnt <= '0;
			end
			if (r_fire) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// The lookup right after the last beat finds the new line
	refill_hit: assert property (@(posedge CLK) disable iff (reset)
		r_done |=> (|hit));

	// Refill goes to a single way
	we_onehot: assert property (@(posedge CLK) disable iff (reset)
		$onehot0(refill_we));

endmodule

// File: design/icache_way_ram.sv
//////////////////////////////////////////////////
// Single way storage RAM
// Registered read, any payload type
//////////////////////////////////////////////////

module icache_way_ram #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 16
) (
	input logic CLK,
	input logic rd_en,
	input logic [$clog2(DEPTH)-1:0] rd_addr,
	input logic wr_en,
	input logic [$clog2(DEPTH)-1:0] wr_addr,
	input entry_t wr_data,
	output entry_t rd_data
);

	entry_t mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read holds its value while rd_en is low
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			// Write-first on an address collision
			if (wr_en && (wr_addr == rd_addr)) begin
				rd_data <= wr_data;
			end else begin
				rd_data <= mem[rd_addr];
			end
		end
	end

endmodule

// File: design/icache_hit_detect.sv
//////////////////////////////////////////////////
// Hit detection
// Valid bits, tag compare and hit beat select
//////////////////////////////////////////////////

`include "icache_settings.svh"

module icache_hit_detect (
	input logic CLK,
	input logic reset,
	input icache_pkg::addr_t lookup_addr,
	input icache_pkg::tag_t tag_rd [`ICACHE_WAYS],
	input icache_pkg::beat_t data_rd [`ICACHE_WAYS],
	input icache_pkg::way_vec_t fill_valid,
	input logic flush,
	output icache_pkg::way_vec_t hit,
	output icache_pkg::way_vec_t valid_set,
	output icache_pkg::beat_t hit_data
);
	import icache_pkg::*;

	way_vec_t valid_q [`ICACHE_SETS];
	index_t lookup_index;
	tag_t lookup_tag;

	assign lookup_index = lookup_addr[BYTE_OFF_W+OFFSET_W +: INDEX_W];
	assign lookup_tag = lookup_addr[`ICACHE_ADDR_W-1 -: TAG_W];
	// Valid bits of the set under lookup
	assign valid_set = valid_q[lookup_index];

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else begin
			// Set at the last refill beat
			valid_q[lookup_index] <= valid_q[lookup_index] | fill_valid;
		end
	end

	always_comb begin
		hit_data = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit[w] = valid_set[w] & (tag_rd[w] == lookup_tag);
			if (hit[w]) begin
				hit_data = data_rd[w];
			end
		end
	end

	// A line is only ever filled into one way
	hit_unique: assert property (@(posedge CLK) disable iff (reset)
		$onehot0(hit));

endmodule

// File: design/icache_victim_sel.sv
//////////////////////////////////////////////////
// Replacement way select
// Lowest invalid way, else LFSR pick
//////////////////////////////////////////////////

`include "icache_settings.svh"

module icache_victim_sel (
	input logic CLK,
	input logic reset,
	input icache_pkg::way_vec_t valid_set,
	output icache_pkg::way_vec_t victim
);
	import icache_pkg::*;

	logic [15:0] lfsr;
	logic free_found;

	// Fibonacci form, taps 16 14 13 11
	always_ff @(posedge CLK) begin
		if (reset) begin
			lfsr <= 16'hace1;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	always_comb begin
		victim = '0;
		free_found = 1'b0;
		// Lowest numbered free way first
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (!valid_set[w] && !free_found) begin
				victim[w] = 1'b1;
				free_found = 1'b1;
			end
		end
		// Set full
		if (!free_found) begin
			victim[lfsr[WAY_W-1:0]] = 1'b1;
		end
	end

endmodule

// File: design/icache_top.sv
//////////////////////////////////////////////////
// Two-way read-only instruction cache
// Fetch valid/ready port, 4-beat memory burst
//////////////////////////////////////////////////

`include "icache_settings.svh"

module icache_top (
	input logic CLK,
	input logic reset,
	input logic ifu_req_valid,
	output logic ifu_req_ready,
	input icache_pkg::addr_t ifu_req_addr,
	output logic ifu_rsp_valid,
	input logic ifu_rsp_ready,
	output icache_pkg::beat_t ifu_rsp_data,
	input logic fence,
	output logic mem_ar_valid,
	input logic mem_ar_ready,
	output icache_pkg::addr_t mem_ar_addr,
	input logic mem_r_valid,
	output logic mem_r_ready,
	input icache_pkg::beat_t mem_r_data,
	input logic mem_r_last
);
	import icache_pkg::*;

	addr_t lookup_addr;
	addr_t rd_src_addr;
	logic req_fire;
	logic lookup_en;
	logic flush;
	way_vec_t hit;
	way_vec_t victim;
	way_vec_t valid_set;
	way_vec_t refill_we;
	way_vec_t fill_valid;
	offset_t refill_offset;
	index_t rd_index;
	index_t lookup_index;
	tag_t lookup_tag;
	data_addr_t rd_data_addr;
	data_addr_t wr_data_addr;
	tag_t tag_rd [`ICACHE_WAYS];
	beat_t data_rd [`ICACHE_WAYS];
	beat_t hit_data;

	assign req_fire = ifu_req_valid & ifu_req_ready;

	// Incoming address on accept, held address for the post-refill lookup
	assign rd_src_addr = req_fire ? ifu_req_addr : lookup_addr;
	assign rd_index = rd_src_addr[BYTE_OFF_W+OFFSET_W +: INDEX_W];
	assign rd_data_addr = {rd_index, rd_src_addr[BYTE_OFF_W +: OFFSET_W]};

	assign lookup_index = lookup_addr[BYTE_OFF_W+OFFSET_W +: INDEX_W];
	assign lookup_tag = lookup_addr[`ICACHE_ADDR_W-1 -: TAG_W];
	assign wr_data_addr = {lookup_index, refill_offset};

	// Burst starts at the line base
	assign mem_ar_addr = {lookup_addr[`ICACHE_ADDR_W-1:BYTE_OFF_W+OFFSET_W],
		{(BYTE_OFF_W + OFFSET_W){1'b0}}};
	assign ifu_rsp_data = hit_data;

	always_ff @(posedge CLK) begin
		if (reset) begin
			lookup_addr <= '0;
		end else if (req_fire) begin
			lookup_addr <= ifu_req_addr;
		end
	end

	icache_ctrl ctrl_inst (
		.CLK(CLK),
		.reset(reset),
		.ifu_req_valid(ifu_req_valid),
		.ifu_req_ready(ifu_req_ready),
		.ifu_rsp_valid(ifu_rsp_valid),
		.ifu_rsp_ready(ifu_rsp_ready),
		.fence(fence),
		.mem_ar_valid(mem_ar_valid),
		.mem_ar_ready(mem_ar_ready),
		.mem_r_valid(mem_r_valid),
		.mem_r_ready(mem_r_ready),
		.mem_r_last(mem_r_last),
		.hit(hit),
		.victim(victim),
		.lookup_en(lookup_en),
		.refill_we(refill_we),
		.refill_offset(refill_offset),
		.fill_valid(fill_valid),
		.flush(flush)
	);

	// Tag and data store, one pair per way
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		// Tag rewritten on every beat of the burst, same value each time
		icache_way_ram #(
			.entry_t(tag_t),
			.DEPTH(`ICACHE_SETS)
		) tag_ram (
			.CLK(CLK),
			.rd_en(lookup_en),
			.rd_addr(rd_index),
			.wr_en(refill_we[w]),
			.wr_addr(lookup_index),
			.wr_data(lookup_tag),
			.rd_data(tag_rd[w])
		);

		icache_way_ram #(
			.entry_t(beat_t),
			.DEPTH(`ICACHE_SETS * `ICACHE_LINE_BEATS)
		) data_ram (
			.CLK(CLK),
			.rd_en(lookup_en),
			.rd_addr(rd_data_addr),
			.wr_en(refill_we[w]),
			.wr_addr(wr_data_addr),
			.wr_data(mem_r_data),
			.rd_data(data_rd[w])
		);
	end

	icache_hit_detect hit_detect_inst (
		.CLK(CLK),
		.reset(reset),
		.lookup_addr(lookup_addr),
		.tag_rd(tag_rd),
		.data_rd(data_rd),
		.fill_valid(fill_valid),
		.flush(flush),
		.hit(hit),
		.valid_set(valid_set),
		.hit_data(hit_data)
	);

	icache_victim_sel victim_sel_inst (
		.CLK(CLK),
		.reset(reset),
		.valid_set(valid_set),
		.victim(victim)
	);

endmodule

// File: dv/icache_checker.sv
//////////////////////////////////////////////////
// Instruction cache response checker
// Tracks fetches in order, compares beats, burst
// addresses and refill counts per test
//////////////////////////////////////////////////

`include "icache_settings.svh"

module icache_checker (
	input logic CLK,
	input logic reset,
	input logic ifu_req_valid,
	input logic ifu_req_ready,
	input icache_pkg::addr_t ifu_req_addr,
	input logic ifu_rsp_valid,
	input logic ifu_rsp_ready,
	input icache_pkg::beat_t ifu_rsp_data,
	input logic fence,
	input logic mem_ar_valid,
	input logic mem_ar_ready,
	input icache_pkg::addr_t mem_ar_addr,
	input logic mem_r_valid,
	input logic mem_r_ready,
	input int test_id,
	input icache_pkg::beat_t exp_data,
	input logic [1:0] exp_refill,
	output int done_cnt,
	output int fail_cnt
);
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	localparam int LINE_BYTES = `ICACHE_LINE_BEATS * `ICACHE_BEAT_W / 8;

	// Fetches accepted and not yet answered with the oldest first
	int q_id [$];
	addr_t q_addr [$];
	beat_t q_data [$];
	logic [1:0] q_flag [$];
	int q_bursts [$];

	// Refill flag 2 stands for either outcome
	function automatic string refill_text(logic [1:0] flag);
		if (flag == 2'd2) begin
			return "0 or 1";
		end
		return $sformatf("%0d", flag);
	endfunction

	always @(posedge CLK) begin
		int id;
		int bursts;
		int last;
		addr_t addr;
		addr_t base;
		beat_t beat;
		logic [1:0] flag;
		logic ok;
		if (reset) begin
			q_id.delete();
			q_addr.delete();
			q_data.delete();
			q_flag.delete();
			q_bursts.delete();
			done_cnt = 0;
			fail_cnt = 0;
		end else begin
			// Response leaves before a new request is taken in the same cycle
			if (ifu_rsp_valid && ifu_rsp_ready) begin
				if (q_id.size() == 0) begin
					$display("Error: a response came back with no fetch outstanding");
					fail_cnt++;
				end else begin
					id = q_id.pop_front();
					addr = q_addr.pop_front();
					beat = q_data.pop_front();
					flag = q_flag.pop_front();
					bursts = q_bursts.pop_front();
					ok = 1'b1;
					if (ifu_rsp_data !== beat) begin
						$display("Fail test %0d fetch %h data: expected %h, actual %h",
							id, addr, beat, ifu_rsp_data);
						ok = 1'b0;
					end
					if ((flag == 2'd2) ? (bursts > 1) : (bursts != int'(flag))) begin
						$display("Fail test %0d fetch %h refills: expected %s, actual %0d",
							id, addr, refill_text(flag), bursts);
						ok = 1'b0;
					end
					if (ok) begin
						$display("ok test %0d fetch %h data %h refills %0d",
							id, addr, ifu_rsp_data, bursts);
					end else begin
						fail_cnt++;
					end
					done_cnt++;
				end
			end
			if (ifu_req_valid && ifu_req_ready) begin
				q_id.push_back(test_id);
				q_addr.push_back(ifu_req_addr);
				q_data.push_back(exp_data);
				q_flag.push_back(exp_refill);
				q_bursts.push_back(0);
			end
			// The cache blocks on a miss so a burst belongs to the newest fetch
			if (mem_ar_valid && mem_ar_ready) begin
				if (q_id.size() == 0) begin
					$display("Error: a memory burst started with no fetch outstanding");
					fail_cnt++;
				end else begin
					last = q_id.size() - 1;
					q_bursts[last] = q_bursts[last] + 1;
					base = q_addr[last] & ~addr_t'(LINE_BYTES - 1);
					if (mem_ar_addr !== base) begin
						$display("Fail test %0d burst address: expected %h, actual %h",
							q_id[last], base, mem_ar_addr);
						fail_cnt++;
					end
				end
			end
			// Every offered beat of a refill is taken at once
			if (mem_r_valid && mem_r_ready !== 1'b1) begin
				$display("Error: the cache held off a memory beat during a refill");
				fail_cnt++;
			end
			if (fence) begin
				$display("ok test %0d fence", test_id);
				done_cnt++;
			end
		end
	end

endmodule

// File: dv/icache_tb.sv
//////////////////////////////////////////////////
// Instruction cache testbench
// Fetches and fences from the stim file, a burst
// memory model and random response stalls
//////////////////////////////////////////////////

`include "icache_settings.svh"

module icache_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	localparam int CYCLES_PER_TEST = 40;
	localparam int BEAT_BYTES = `ICACHE_BEAT_W / 8;

	logic CLK = 1'b0;
	logic reset;
	logic ifu_req_valid;
	logic ifu_req_ready;
	addr_t ifu_req_addr;
	logic ifu_rsp_valid;
	logic ifu_rsp_ready = 1'b0;
	beat_t ifu_rsp_data;
	logic fence;
	logic mem_ar_valid;
	logic mem_ar_ready = 1'b0;
	addr_t mem_ar_addr;
	logic mem_r_valid = 1'b0;
	logic mem_r_ready;
	beat_t mem_r_data = '0;
	logic mem_r_last = 1'b0;

	int test_id;
	beat_t exp_data;
	logic [1:0] exp_refill;
	logic req_taken = 1'b0;
	int done_cnt;
	int fail_cnt;
	int load_errs;
	int n_tests;
	int cycles = 0;
	int cycle_limit = 0;
	integer seed = 83196;

	// Test list as read from the stim file
	byte kind_q [$];
	addr_t addr_q [$];
	beat_t data_q [$];
	logic [1:0] flag_q [$];

	always #4 CLK = ~CLK;

	icache_top icache_top_inst (
		.CLK(CLK),
		.reset(reset),
		.ifu_req_valid(ifu_req_valid),
		.ifu_req_ready(ifu_req_ready),
		.ifu_req_addr(ifu_req_addr),
		.ifu_rsp_valid(ifu_rsp_valid),
		.ifu_rsp_ready(ifu_rsp_ready),
		.ifu_rsp_data(ifu_rsp_data),
		.fence(fence),
		.mem_ar_valid(mem_ar_valid),
		.mem_ar_ready(mem_ar_ready),
		.mem_ar_addr(mem_ar_addr),
		.mem_r_valid(mem_r_valid),
		.mem_r_ready(mem_r_ready),
		.mem_r_data(mem_r_data),
		.mem_r_last(mem_r_last)
	);

	icache_checker checker_inst (
		.CLK(CLK),
		.reset(reset),
		.ifu_req_valid(ifu_req_valid),
		.ifu_req_ready(ifu_req_ready),
		.ifu_req_addr(ifu_req_addr),
		.ifu_rsp_valid(ifu_rsp_valid),
		.ifu_rsp_ready(ifu_rsp_ready),
		.ifu_rsp_data(ifu_rsp_data),
		.fence(fence),
		.mem_ar_valid(mem_ar_valid),
		.mem_ar_ready(mem_ar_ready),
		.mem_ar_addr(mem_ar_addr),
		.mem_r_valid(mem_r_valid),
		.mem_r_ready(mem_r_ready),
		.test_id(test_id),
		.exp_data(exp_data),
		.exp_refill(exp_refill),
		.done_cnt(done_cnt),
		.fail_cnt(fail_cnt)
	);

	// Upper word holds the beat's byte address and the lower word its inverse
	function automatic beat_t mem_beat(addr_t addr);
		return {addr, ~addr};
	endfunction

	// Takes the burst address and then streams the four beats of the line
	task automatic serve_burst();
		addr_t base;
		int k;
		logic ready_now;
		base = mem_ar_addr;
		mem_ar_ready = 1'b1;
		@(negedge CLK);
		mem_ar_ready = 1'b0;
		k = 0;
		while (k < `ICACHE_LINE_BEATS) begin
			mem_r_valid = 1'b1;
			mem_r_data = mem_beat(base + addr_t'(k * BEAT_BYTES));
			mem_r_last = (k == `ICACHE_LINE_BEATS - 1);
			// Ready only changes on the rising edge
			ready_now = mem_r_ready;
			@(negedge CLK);
			if (ready_now) begin
				k++;
			end
		end
		mem_r_valid = 1'b0;
		mem_r_last = 1'b0;
	endtask

	always begin
		@(negedge CLK);
		if (mem_ar_valid === 1'b1) begin
			serve_burst();
		end
	end

	// Roughly one cycle in four stalls the response
	always @(negedge CLK) begin
		ifu_rsp_ready = ($random(seed) % 4) != 0;
	end

	// Request handshake seen at the last rising edge
	always @(posedge CLK) begin
		req_taken <= ifu_req_valid & ifu_req_ready;
		cycles <= cycles + 1;
	end

	always @(negedge CLK) begin
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles with %0d of %0d tests finished",
				cycles, done_cnt, n_tests);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int fd;
		int r;
		int c;
		byte kind;
		byte flag_ch;
		addr_t addr;
		beat_t data;
		reset = 1'b1;
		ifu_req_valid = 1'b0;
		ifu_req_addr = '0;
		fence = 1'b0;
		test_id = 0;
		exp_data = '0;
		exp_refill = 2'd0;
		load_errs = 0;
		fd = $fopen("dv/icache_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stim file dv/icache_stim.txt");
			load_errs++;
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				if (kind == "#") begin
					// Skip the rest of a comment line
					c = $fgetc(fd);
					while (c != 10 && c != -1) begin
						c = $fgetc(fd);
					end
				end else begin
					r = $fscanf(fd, " %h %h %c", addr, data, flag_ch);
					if (r != 3) begin
						$display("Stim file entry %0d is malformed", kind_q.size() + 1);
						load_errs++;
					end
					kind_q.push_back(kind);
					addr_q.push_back(addr);
					data_q.push_back(data);
					flag_q.push_back((flag_ch == "x" || flag_ch == "X") ? 2'd2 :
						((flag_ch == "1") ? 2'd1 : 2'd0));
				end
			end
			$fclose(fd);
		end
		n_tests = kind_q.size();
		cycle_limit = CYCLES_PER_TEST * n_tests;

		repeat (8) @(negedge CLK);
		reset = 1'b0;

		for (int i = 0; i < n_tests; i++) begin
			test_id = i + 1;
			if (kind_q[i] == "F") begin
				fence = 1'b1;
				@(negedge CLK);
				fence = 1'b0;
			end else begin
				ifu_req_valid = 1'b1;
				ifu_req_addr = addr_q[i];
				exp_data = data_q[i];
				exp_refill = flag_q[i];
				@(negedge CLK);
				while (!req_taken) begin
					@(negedge CLK);
				end
				ifu_req_valid = 1'b0;
			end
		end

		while (done_cnt < n_tests) begin
			@(negedge CLK);
		end
		$display("Tests finished %0d of %0d, failed checks %0d",
			done_cnt, n_tests, fail_cnt + load_errs);
		if (fail_cnt == 0 && load_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: dv/icache_stim.txt
# Columns: kind (R fetch, F fence), fetch address, expected beat, expected refill
# Refill 1 is one burst, 0 none, x either; fence lines carry zero fields
# Cold fetch, then the rest of the same line
R 00001008 00001008ffffeff7 1
R 00001000 00001000ffffefff 0
R 00001010 00001010ffffefef 0
R 0000101c 00001018ffffefe7 0
R 00001008 00001008ffffeff7 0
# Second line in set 0, both stay resident
R 00001200 00001200ffffedff 1
R 00001000 00001000ffffefff 0
R 00001208 00001208ffffedf7 0
# Third line in set 0 evicts one of them
R 00001404 00001400ffffebff 1
R 00001000 00001000ffffefff x
R 00001200 00001200ffffedff x
R 00001410 00001410ffffebef x
# Fence, then a resident line refills again
F 00000000 0000000000000000 0
R 00001008 00001008ffffeff7 1
R 00001010 00001010ffffefef 0
# Sets 1 and 15, interleaved
R 00002020 00002020ffffdfdf 1
R 00002028 00002028ffffdfd7 0
R 000001e8 000001e8fffffe17 1
R 00002034 00002030ffffdfcf 0
R 000001f4 000001f0fffffe0f 0
R 00002038 00002038ffffdfc7 0

// File: sources.f
+incdir+design
design/icache_pkg.sv
design/icache_ctrl.sv
design/icache_way_ram.sv
design/icache_hit_detect.sv
design/icache_victim_sel.sv
design/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f sources.f --top-module icache_tb -Mdir obj_dir -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -qx "No errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
